//--- bench/avmm_mem_model.sv
/*
 * Avalon-MM read slave model, random wait request, read data is the
 * line address replicated across the data bus
 */
`timescale 1ns/1ps
`default_nettype none

module avmm_mem_model
  import avmm_rd_pkg::*;
#(
  parameter logic [31:0] SEED = 32'hee3e_56c5
) (
  input  wire               Clk_i,
  input  wire               Srst_i,
  input  wire avmm_rd_req_t req_i,
  input  wire               rand_wait_i,
  output logic              waitreq_o,
  output logic              rdata_valid_o,
  output logic [DATA_W-1:0] rdata_o
);

  logic [63:0] beat_q [$];
  integer      seed;

  initial
  begin
    seed          = SEED;
    waitreq_o     = 1'b0;
    rdata_valid_o = 1'b0;
    rdata_o       = '0;
  end

  // a burst is taken on the edge where read is high and wait is low
  always @(negedge Clk_i)
  begin
    if (Srst_i)
    begin
      beat_q.delete();
    end
    else if (req_i.read && !waitreq_o)
    begin
      for (int i = 0; i < int'(req_i.burstcount); i++)
      begin
        beat_q.push_back({req_i.address[63:5], 5'b00000} + (64'(i) << 5));
      end
    end
  end

  // outputs change shortly after the rising edge
  always @(posedge Clk_i)
  begin
    logic [31:0] rnd;
    logic [63:0] line_addr;
    #1;
    rnd           = $random(seed);
    waitreq_o     = rand_wait_i && rnd[0];
    rdata_valid_o = (beat_q.size() != 0) && (!rand_wait_i || rnd[1]);
    if (rdata_valid_o)
    begin
      line_addr = beat_q.pop_front();
      rdata_o   = {4{line_addr}};
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_wrdma_rd.sv
/*
 * testbench for the write-DMA read engine that checks bursts, buffer
 * contents, done flags and credit throttling
 */
`timescale 1ns/1ps
`default_nettype none

module tb_wrdma_rd
  import dma_desc_pkg::*;
  import avmm_rd_pkg::*;
();

  localparam logic [31:0] SEED    = 32'hee3e_56c5;
  localparam int          TIMEOUT = 20000;

  typedef avmm_rd_req_t req_list_t[$];

  logic              clk;
  logic              srst;
  desc_t             desc;
  logic              desc_valid;
  logic              desc_ready;
  avmm_rd_req_t      avmm_req;
  logic              waitreq;
  logic              rdata_valid;
  logic [DATA_W-1:0] rdata;
  buff_addr_t        ram_rd_addr;
  logic [DATA_W-1:0] ram_rd_data;
  logic              buff_release;
  logic [8:0]        release_size;
  logic              done_pop;
  logic [4:0]        done_count;
  logic              rand_wait;

  integer       seed;
  string        test_name;
  avmm_rd_req_t exp_q [$];
  logic [63:0]  line_addr_q [$];
  int           desc_lines_q [$];
  avmm_rd_req_t held_req;
  logic         hold_valid;
  logic [4:0]   prev_done;
  int           consumed_lines;
  int           released_lines;
  int           lines_returned;
  int           done_lines;
  int           accept_cnt;
  int           chk_idx;

  wrdma_rd_top #(
    .DESC_FIFO_DEPTH (6),
    .DONE_FIFO_DEPTH (16)
  ) dut (
    .Clk_i               (clk),
    .Srst_i              (srst),
    .desc_i              (desc),
    .desc_valid_i        (desc_valid),
    .desc_ready_o        (desc_ready),
    .avmm_req_o          (avmm_req),
    .avmm_waitreq_i      (waitreq),
    .avmm_rdata_valid_i  (rdata_valid),
    .avmm_rdata_i        (rdata),
    .ram_rd_addr_i       (ram_rd_addr),
    .ram_rd_data_o       (ram_rd_data),
    .buff_release_i      (buff_release),
    .buff_release_size_i (release_size),
    .done_pop_i          (done_pop),
    .done_count_o        (done_count)
  );

  avmm_mem_model #(
    .SEED (SEED)
  ) u_mem (
    .Clk_i         (clk),
    .Srst_i        (srst),
    .req_i         (avmm_req),
    .rand_wait_i   (rand_wait),
    .waitreq_o     (waitreq),
    .rdata_valid_o (rdata_valid),
    .rdata_o       (rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_req(input string name, input avmm_rd_req_t exp_v,
                           input avmm_rd_req_t act_v);
    if (act_v !== exp_v)
    begin
      report_failure($sformatf("error %s: expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_line(input string name, input logic [DATA_W-1:0] exp_v,
                            input logic [DATA_W-1:0] act_v);
    if (act_v !== exp_v)
    begin
      report_failure($sformatf("error %s: expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_count(input string name, input logic [4:0] exp_v,
                             input logic [4:0] act_v);
    if (act_v !== exp_v)
    begin
      report_failure($sformatf("error %s: expected %0d actual %0d", name, exp_v, act_v));
    end
  endtask

  // byte enables for n dwords starting at dword first
  function automatic logic [BE_W-1:0] dw_bytes(input int first, input int n);
    logic [BE_W-1:0] be;
    be = '0;
    for (int i = first; i < first + n; i++)
    begin
      be[4*i +: 4] = 4'hf;
    end
    return be;
  endfunction

  // head to the line boundary, then 16-line bursts, whole lines, tail
  function automatic req_list_t expected_bursts(input desc_t d);
    req_list_t    reqs;
    avmm_rd_req_t r;
    logic [63:0]  addr;
    int           rem;
    int           off;
    int           n;
    addr = d.src_addr;
    rem  = int'(d.dw_count);
    while (rem > 0)
    begin
      r.read       = 1'b1;
      r.address    = addr;
      r.byteenable = '1;
      r.burstcount = 5'd1;
      off          = int'(addr[4:2]);
      if (addr[4:0] != 5'd0)
      begin
        n = (rem < 8 - off) ? rem : 8 - off;
        r.byteenable = dw_bytes(off, n);
      end
      else if (rem >= 128)
      begin
        n = 128;
        r.burstcount = 5'd16;
      end
      else if (rem < 8)
      begin
        n = rem;
        r.byteenable = dw_bytes(0, n);
      end
      else
      begin
        n = rem - rem % 8;
        r.burstcount = 5'(n / 8);
      end
      reqs.push_back(r);
      addr = addr + 64'(n * 4);
      rem  = rem - n;
    end
    return reqs;
  endfunction

  function automatic int lines_of(input req_list_t reqs);
    int total;
    total = 0;
    foreach (reqs[i])
    begin
      total += int'(reqs[i].burstcount);
    end
    return total;
  endfunction

  // request monitor that compares every accepted burst in order
  always @(negedge clk)
  begin
    avmm_rd_req_t exp_req;
    if (!srst)
    begin
      if (hold_valid)
      begin
        check_req({test_name, " hold"}, held_req, avmm_req);
      end
      hold_valid = avmm_req.read && waitreq;
      held_req   = avmm_req;
      if (avmm_req.read && !waitreq)
      begin
        if (exp_q.size() == 0)
        begin
          report_failure("a read burst was issued that no descriptor asked for");
        end
        exp_req = exp_q.pop_front();
        check_req(test_name, exp_req, avmm_req);
        if (consumed_lines > BUFF_MARGIN + released_lines)
        begin
          report_failure("a read burst was issued without buffer credit");
        end
        for (int i = 0; i < int'(exp_req.burstcount); i++)
        begin
          line_addr_q.push_back({exp_req.address[63:5], 5'b00000} + (64'(i) << 5));
        end
        consumed_lines += int'(exp_req.burstcount);
        accept_cnt++;
      end
    end
  end

  // returned lines and done flags
  always @(negedge clk)
  begin
    if (srst)
    begin
      prev_done = '0;
    end
    else
    begin
      if (rdata_valid)
      begin
        lines_returned++;
      end
      if (done_count == prev_done + 5'd1)
      begin
        if (desc_lines_q.size() == 0)
        begin
          report_failure("a done flag came with no descriptor in flight");
        end
        done_lines += desc_lines_q.pop_front();
        if (lines_returned < done_lines)
        begin
          report_failure("a descriptor was flagged done before all its lines came back");
        end
      end
      prev_done = done_count;
    end
  end

  task automatic send_desc(input desc_t d);
    req_list_t reqs;
    int        wait_cnt;
    reqs = expected_bursts(d);
    @(posedge clk);
    #1;
    desc       = d;
    desc_valid = 1'b1;
    foreach (reqs[i])
    begin
      exp_q.push_back(reqs[i]);
    end
    desc_lines_q.push_back(lines_of(reqs));
    wait_cnt = 0;
    @(negedge clk);
    while (!desc_ready)
    begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT)
      begin
        report_failure("the descriptor input never became ready");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    desc_valid = 1'b0;
  endtask

  task automatic wait_requests_drained();
    int wait_cnt;
    wait_cnt = 0;
    while (exp_q.size() != 0)
    begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT)
      begin
        report_failure("expected read bursts never appeared on the read master");
      end
      @(posedge clk);
    end
  endtask

  task automatic wait_lines_in();
    int wait_cnt;
    wait_cnt = 0;
    while (lines_returned != consumed_lines)
    begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT)
      begin
        report_failure("read data for the accepted bursts never came back");
      end
      @(posedge clk);
    end
  endtask

  task automatic wait_credit_stall();
    int wait_cnt;
    wait_cnt = 0;
    while (consumed_lines <= BUFF_MARGIN + released_lines)
    begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT)
      begin
        report_failure("the consumed lines never passed the credit limit");
      end
      @(posedge clk);
    end
  endtask

  task automatic wait_done_count(input int n_desc);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge clk);
    while (done_count != 5'(n_desc))
    begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT)
      begin
        report_failure("the done count never reached the number of descriptors");
      end
      @(negedge clk);
    end
  endtask

  task automatic release_lines(input int total);
    int chunk;
    while (total > 0)
    begin
      chunk = (total > 511) ? 511 : total;
      @(posedge clk);
      #1;
      buff_release   = 1'b1;
      release_size   = 9'(chunk);
      released_lines += chunk;
      @(posedge clk);
      #1;
      buff_release = 1'b0;
      total -= chunk;
    end
  endtask

  // reads back every line not yet checked, then hands the credit back
  task automatic check_buffer_and_release();
    logic [DATA_W-1:0] exp_line;
    logic [63:0]       line_addr;
    int                target;
    int                n;
    n = 0;
    repeat (3) @(posedge clk);
    target = lines_returned;
    while (chk_idx < target)
    begin
      @(posedge clk);
      #1;
      ram_rd_addr = buff_addr_t'(chk_idx % BUFF_LINES);
      line_addr   = line_addr_q.pop_front();
      exp_line    = {4{line_addr}};
      @(posedge clk);
      @(negedge clk);
      check_line({test_name, " buffer"}, exp_line, ram_rd_data);
      chk_idx++;
      n++;
    end
    release_lines(n);
  endtask

  task automatic pop_done(input int n_desc);
    for (int i = 0; i < n_desc; i++)
    begin
      @(posedge clk);
      #1;
      done_pop = 1'b1;
      @(posedge clk);
      #1;
      done_pop = 1'b0;
    end
    @(negedge clk);
  endtask

  task automatic finish_test(input int n_desc);
    wait_requests_drained();
    wait_lines_in();
    wait_done_count(n_desc);
    check_buffer_and_release();
    check_count({test_name, " done"}, 5'(n_desc), done_count);
    pop_done(n_desc);
    check_count({test_name, " popped"}, 5'd0, done_count);
  endtask

  initial
  begin
    desc_t       d;
    logic [31:0] rnd;
    int          stall_cnt;
    seed           = SEED;
    srst           = 1'b1;
    desc           = '0;
    desc_valid     = 1'b0;
    ram_rd_addr    = '0;
    buff_release   = 1'b0;
    release_size   = '0;
    done_pop       = 1'b0;
    rand_wait      = 1'b0;
    hold_valid     = 1'b0;
    consumed_lines = 0;
    released_lines = 0;
    lines_returned = 0;
    done_lines     = 0;
    accept_cnt     = 0;
    chk_idx        = 0;
    test_name      = "reset";
    repeat (2) @(posedge clk);
    #1;
    srst = 1'b0;
    @(negedge clk);
    check_count(test_name, 5'd0, done_count);
    if (avmm_req.read || dut.u_splitter.state != IDLE)
    begin
      report_failure("the read master was not idle after reset");
    end

    // two full 16-line bursts
    test_name  = "aligned_max";
    d.desc_id  = 8'd1;
    d.dw_count = 18'd256;
    d.src_addr = 64'h0000_0000_0010_0000;
    send_desc(d);
    finish_test(1);

    // head, one whole line, tail
    test_name  = "offset_head_tail";
    d.desc_id  = 8'd2;
    d.dw_count = 18'd20;
    d.src_addr = 64'h0000_0001_0000_200c;
    send_desc(d);
    finish_test(1);

    test_name = "random";
    rand_wait = 1'b1;
    for (int k = 0; k < 10; k++)
    begin
      rnd        = $random(seed);
      d.desc_id  = 8'(k + 16);
      d.dw_count = 18'(1 + (rnd & 32'h0ff));
      rnd        = $random(seed);
      d.src_addr = {32'h0000_0002, rnd[31:2], 2'b00};
      send_desc(d);
    end
    finish_test(10);

    // 512 lines against 447 lines of credit
    test_name  = "credit";
    d.desc_id  = 8'd40;
    d.dw_count = 18'd2048;
    d.src_addr = 64'h0000_0004_0000_0000;
    send_desc(d);
    d.desc_id  = 8'd41;
    d.src_addr = 64'h0000_0004_0001_0000;
    send_desc(d);
    wait_credit_stall();
    stall_cnt = accept_cnt;
    repeat (40) @(posedge clk);
    if (accept_cnt != stall_cnt || exp_q.size() == 0)
    begin
      report_failure("reads went on after the credit ran out");
    end
    wait_lines_in();
    check_buffer_and_release();
    finish_test(2);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
verilog/dma_desc_pkg.sv
verilog/avmm_rd_pkg.sv
verilog/sync_fifo.sv
verilog/rd_burst_splitter.sv
verilog/rd_credit_ctrl.sv
verilog/cpl_data_buffer.sv
verilog/desc_done_tracker.sv
verilog/wrdma_rd_top.sv
bench/avmm_mem_model.sv
bench/tb_wrdma_rd.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the write-DMA read engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_wrdma_rd \
  -f build.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
exit 1

//--- verilog/avmm_rd_pkg.sv
/*
 * Avalon-MM read master definitions
 */
`default_nettype none

package avmm_rd_pkg;

  localparam int DATA_W = 256;
  localparam int BE_W   = 32;

  // largest burst in lines (512 bytes)
  localparam int MAX_BURST = 16;

  typedef logic [4:0] burst_t;

  typedef struct packed {
    logic            read;
    logic [63:0]     address;
    logic [BE_W-1:0] byteenable;
    burst_t          burstcount;
  } avmm_rd_req_t;

endpackage

`default_nettype wire

//--- verilog/cpl_data_buffer.sv
/*
 * completion data buffer, 512 lines written in arrival order
 */
`timescale 1ns/1ps
`default_nettype none

module cpl_data_buffer
  import dma_desc_pkg::*;
  import avmm_rd_pkg::*;
(
  input  wire              Clk_i,
  input  wire              Srst_i,
  input  wire              rdata_valid_i,
  input  wire [DATA_W-1:0] rdata_i,
  input  wire buff_addr_t  rd_addr_i,
  output logic [DATA_W-1:0] rd_data_o,
  output logic             line_wr_o
);

  logic [DATA_W-1:0] ram [BUFF_LINES];
  logic [DATA_W-1:0] rdata_q;
  buff_addr_t        wr_ptr;
  buff_addr_t        rd_addr_q;

  always_ff @(posedge Clk_i)
  begin
    rdata_q   <= rdata_i;
    rd_addr_q <= rd_addr_i;
    if (line_wr_o)
    begin
      ram[wr_ptr] <= rdata_q;
    end
  end

  // pointer wraps at the buffer size
  always_ff @(posedge Clk_i)
  begin
    if (Srst_i)
    begin
      line_wr_o <= 1'b0;
      wr_ptr    <= '0;
    end
    else
    begin
      line_wr_o <= rdata_valid_i;
      if (line_wr_o)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  assign rd_data_o = ram[rd_addr_q];

endmodule

`default_nettype wire

//--- verilog/desc_done_tracker.sv
/*
 * per-descriptor completion tracking, flags a descriptor once all its
 * lines are in the buffer
 */
`timescale 1ns/1ps
`default_nettype none

module desc_done_tracker
  import dma_desc_pkg::*;
#(
  parameter int DONE_FIFO_DEPTH = 16
) (
  input  wire        Clk_i,
  input  wire        Srst_i,
  input  wire desc_t desc_load_i,
  input  wire        desc_loaded_i,
  input  wire        line_wr_i,
  input  wire        done_pop_i,
  output logic [$clog2(DONE_FIFO_DEPTH+1)-1:0] done_count_o
);

  logic [18:0]                          adj_dw;
  line_cnt_t                            exp_lines;
  line_cnt_t                            head_lines;
  logic [$clog2(DONE_FIFO_DEPTH+1)-1:0] lc_count;
  line_cnt_t                            line_cnt;
  logic                                 term_cnt;

  // lines touched = dwords plus leading line offset, rounded up
  assign adj_dw    = {1'b0, desc_load_i.dw_count} + 19'(desc_load_i.src_addr[4:2])
                     + 19'(LINE_DW - 1);
  assign exp_lines = adj_dw[18:3];

  sync_fifo #(
    .WIDTH ($bits(line_cnt_t)),
    .DEPTH (DONE_FIFO_DEPTH)
  ) u_line_cnt_fifo (
    .Clk_i     (Clk_i),
    .Srst_i    (Srst_i),
    .wr_i      (desc_loaded_i),
    .wr_data_i (exp_lines),
    .rd_i      (term_cnt),
    .rd_data_o (head_lines),
    .count_o   (lc_count)
  );

  assign term_cnt = (lc_count != '0) && (line_cnt == head_lines);

  // a line written on the terminal cycle belongs to the next descriptor
  always_ff @(posedge Clk_i)
  begin
    if (Srst_i)
    begin
      line_cnt <= '0;
    end
    else if (term_cnt)
    begin
      line_cnt <= line_wr_i ? line_cnt_t'(1) : '0;
    end
    else if (line_wr_i)
    begin
      line_cnt <= line_cnt + 1'b1;
    end
  end

  sync_fifo #(
    .WIDTH (1),
    .DEPTH (DONE_FIFO_DEPTH)
  ) u_done_fifo (
    .Clk_i     (Clk_i),
    .Srst_i    (Srst_i),
    .wr_i      (term_cnt),
    .wr_data_i (1'b1),
    .rd_i      (done_pop_i),
    .rd_data_o (),
    .count_o   (done_count_o)
  );

endmodule

`default_nettype wire

//--- verilog/dma_desc_pkg.sv
/*
 * descriptor definitions for the write-DMA read engine
 * descriptor layout, line and buffer sizing, request FSM states
 */
`default_nettype none

package dma_desc_pkg;

  // descriptor as it arrives on the input stream
  typedef struct packed {
    logic [7:0]  desc_id;
    logic [17:0] dw_count;
    logic [63:0] src_addr;
  } desc_t;

  // one buffer line is one 256-bit read beat
  localparam int LINE_BYTES = 32;
  localparam int LINE_DW    = 8;

  // completion buffer sizing
  localparam int BUFF_LINES = 512;
  typedef logic [8:0] buff_addr_t;

  // initial credit limit, keeps some headroom below BUFF_LINES
  localparam int BUFF_MARGIN = 447;

  typedef enum logic [3:0] {
    IDLE,
    POP_DESC,
    CHECK_DESC,
    SEND_HEAD,
    SEND_MAX,
    SEND_LAST,
    SEND_TAIL,
    ADDER_PIPE,
    UPDATE_DESC
  } rd_state_e;

  typedef logic [15:0] line_cnt_t;

endpackage

`default_nettype wire

//--- verilog/rd_burst_splitter.sv
/*
 * read request FSM, splits a descriptor into head, max, last and tail
 * Avalon-MM bursts and generates the partial byte enables
 */
`timescale 1ns/1ps
`default_nettype none

module rd_burst_splitter
  import dma_desc_pkg::*;
  import avmm_rd_pkg::*;
(
  input  wire           Clk_i,
  input  wire           Srst_i,
  input  wire desc_t    head_desc_i,
  input  wire           fifo_empty_i,
  output logic          desc_pop_o,
  input  wire           credit_ok_i,
  input  wire           avmm_waitreq_i,
  output avmm_rd_req_t  avmm_req_o,
  output desc_t         desc_load_o,
  output logic          desc_loaded_o
);

  localparam int MAX_DW = MAX_BURST * LINE_DW;
  localparam int OFS_W  = $clog2(LINE_BYTES);

  rd_state_e          state;
  rd_state_e          nxt_state;
  logic [63:0]        cur_addr;
  logic [63:0]        addr_sum;
  logic [17:0]        remain_dw;
  logic [2:0]         off_dw;
  logic [3:0]         dw_to_line;
  logic [3:0]         head_dw;
  logic               all_dw_done;
  logic [7:0]         rd_dw;
  logic [15:0]        head_span;
  logic [8:0]         tail_span;
  logic [LINE_DW-1:0] head_mask;
  logic [LINE_DW-1:0] tail_mask;
  logic               send;
  logic               accept;

  // expand a dword mask to byte enables
  function automatic logic [BE_W-1:0] dw_to_be(input logic [LINE_DW-1:0] dw_mask);
    logic [BE_W-1:0] be;
    for (int i = 0; i < LINE_DW; i++)
    begin
      be[4*i +: 4] = {4{dw_mask[i]}};
    end
    return be;
  endfunction

  assign send   = state inside {SEND_HEAD, SEND_MAX, SEND_LAST, SEND_TAIL};
  assign accept = send && !avmm_waitreq_i;

  assign desc_pop_o = (state == POP_DESC);

  // head burst stops at the next line boundary or at the end of the descriptor
  assign off_dw      = cur_addr[4:2];
  assign dw_to_line  = 4'd8 - {1'b0, off_dw};
  assign head_dw     = (remain_dw < dw_to_line) ? remain_dw[3:0] : dw_to_line;
  assign all_dw_done = (remain_dw <= dw_to_line);

  always_comb
  begin
    head_span = ((16'd1 << head_dw) - 16'd1) << off_dw;
    tail_span = (9'd1 << remain_dw[2:0]) - 9'd1;
    head_mask = head_span[LINE_DW-1:0];
    tail_mask = tail_span[LINE_DW-1:0];
  end

  // dwords covered by the burst in flight
  always_comb
  begin
    case (state)
      SEND_HEAD: rd_dw = {4'b0, head_dw};
      SEND_MAX:  rd_dw = 8'(MAX_DW);
      SEND_LAST: rd_dw = {remain_dw[7:3], 3'b000};
      default:   rd_dw = {5'b0, remain_dw[2:0]};
    endcase
  end

  always_comb
  begin
    avmm_req_o.read    = send;
    avmm_req_o.address = cur_addr;
    case (state)
      SEND_HEAD: avmm_req_o.byteenable = dw_to_be(head_mask);
      SEND_TAIL: avmm_req_o.byteenable = dw_to_be(tail_mask);
      default:   avmm_req_o.byteenable = '1;
    endcase
    case (state)
      SEND_MAX:  avmm_req_o.burstcount = burst_t'(MAX_BURST);
      SEND_LAST: avmm_req_o.burstcount = remain_dw[7:3];
      default:   avmm_req_o.burstcount = 5'd1;
    endcase
  end

  always_comb
  begin
    nxt_state = state;
    case (state)
      IDLE:
        if (!fifo_empty_i)
        begin
          nxt_state = POP_DESC;
        end
      POP_DESC:
        nxt_state = CHECK_DESC;
      CHECK_DESC:
        if (credit_ok_i)
        begin
          if (cur_addr[OFS_W-1:0] != '0)
            nxt_state = SEND_HEAD;
          else if (remain_dw >= MAX_DW)
            nxt_state = SEND_MAX;
          else if (remain_dw < LINE_DW)
            nxt_state = SEND_TAIL;
          else
            nxt_state = SEND_LAST;
        end
      SEND_HEAD:
        if (!avmm_waitreq_i)
        begin
          nxt_state = all_dw_done ? IDLE : ADDER_PIPE;
        end
      SEND_MAX, SEND_LAST:
        if (!avmm_waitreq_i)
        begin
          nxt_state = ADDER_PIPE;
        end
      SEND_TAIL:
        if (!avmm_waitreq_i)
        begin
          nxt_state = IDLE;
        end
      ADDER_PIPE:
        nxt_state = (remain_dw == '0) ? IDLE : UPDATE_DESC;
      UPDATE_DESC:
        nxt_state = CHECK_DESC;
      default:
        nxt_state = IDLE;
    endcase
  end

  always_ff @(posedge Clk_i)
  begin
    if (Srst_i)
    begin
      state         <= IDLE;
      desc_loaded_o <= 1'b0;
    end
    else
    begin
      state         <= nxt_state;
      desc_loaded_o <= (state == POP_DESC);
    end
  end

  // registered adder, result is picked up in ADDER_PIPE
  always_ff @(posedge Clk_i)
  begin
    addr_sum <= cur_addr + (64'(rd_dw) << 2);
  end

  always_ff @(posedge Clk_i)
  begin
    if (state == POP_DESC)
    begin
      cur_addr    <= head_desc_i.src_addr;
      remain_dw   <= head_desc_i.dw_count;
      desc_load_o <= head_desc_i;
    end
    else
    begin
      if (state == ADDER_PIPE)
      begin
        cur_addr <= addr_sum;
      end
      if (accept)
      begin
        remain_dw <= remain_dw - 18'(rd_dw);
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/rd_credit_ctrl.sv
/*
 * completion buffer credits, throttles new bursts until lines are released
 */
`timescale 1ns/1ps
`default_nettype none

module rd_credit_ctrl
  import dma_desc_pkg::*;
  import avmm_rd_pkg::*;
(
  input  wire         Clk_i,
  input  wire         Srst_i,
  input  wire         burst_accept_i,
  input  wire burst_t burst_lines_i,
  input  wire         release_i,
  input  wire  [8:0]  release_size_i,
  output logic        credit_ok_o
);

  logic       release_q;
  logic [8:0] release_size_q;
  logic [9:0] limit_cnt;
  logic [9:0] consumed_cnt;
  logic [9:0] headroom;

  always_ff @(posedge Clk_i)
  begin
    release_size_q <= release_size_i;
  end

  always_ff @(posedge Clk_i)
  begin
    if (Srst_i)
    begin
      release_q    <= 1'b0;
      limit_cnt    <= 10'(BUFF_MARGIN);
      consumed_cnt <= '0;
      credit_ok_o  <= 1'b0;
    end
    else
    begin
      release_q <= release_i;
      if (release_q)
      begin
        limit_cnt <= limit_cnt + 10'(release_size_q);
      end
      if (burst_accept_i)
      begin
        consumed_cnt <= consumed_cnt + 10'(burst_lines_i);
      end
      credit_ok_o <= (headroom <= BUFF_LINES);
    end
  end

  // wraps to a large value once consumed passes the limit
  assign headroom = limit_cnt - consumed_cnt;

endmodule

`default_nettype wire

//--- verilog/sync_fifo.sv
/*
 * synchronous show-ahead FIFO, register array with occupancy count
 */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  wire                          Clk_i,
  input  wire                          Srst_i,
  input  wire                          wr_i,
  input  wire  [WIDTH-1:0]             wr_data_i,
  input  wire                          rd_i,
  output logic [WIDTH-1:0]             rd_data_o,
  output logic [$clog2(DEPTH+1)-1:0]   count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_wr;
  logic             do_rd;

  // writes to a full FIFO and reads from an empty one are dropped
  assign do_wr = wr_i && (count_o < DEPTH);
  assign do_rd = rd_i && (count_o != '0);

  // head is visible as long as count_o is non-zero
  assign rd_data_o = mem[rd_ptr];

  always_ff @(posedge Clk_i)
  begin
    if (do_wr)
    begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (Srst_i)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end
    else
    begin
      if (do_wr)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/wrdma_rd_top.sv
/*
 * write-DMA read engine top, descriptor FIFO, burst splitter, credits,
 * completion buffer and done tracking
 */
`timescale 1ns/1ps
`default_nettype none

module wrdma_rd_top
  import dma_desc_pkg::*;
  import avmm_rd_pkg::*;
#(
  parameter int DESC_FIFO_DEPTH = 6,
  parameter int DONE_FIFO_DEPTH = 16
) (
  input  wire               Clk_i,
  input  wire               Srst_i,
  input  wire desc_t        desc_i,
  input  wire               desc_valid_i,
  output logic              desc_ready_o,
  output avmm_rd_req_t      avmm_req_o,
  input  wire               avmm_waitreq_i,
  input  wire               avmm_rdata_valid_i,
  input  wire [DATA_W-1:0]  avmm_rdata_i,
  input  wire buff_addr_t   ram_rd_addr_i,
  output logic [DATA_W-1:0] ram_rd_data_o,
  input  wire               buff_release_i,
  input  wire [8:0]         buff_release_size_i,
  input  wire               done_pop_i,
  output logic [$clog2(DONE_FIFO_DEPTH+1)-1:0] done_count_o
);

  desc_t                                head_desc;
  logic [$clog2(DESC_FIFO_DEPTH+1)-1:0] desc_cnt;
  logic                                 desc_pop;
  desc_t                                desc_load;
  logic                                 desc_loaded;
  logic                                 credit_ok;
  logic                                 burst_accept;
  logic                                 line_wr;

  // leave room for descriptors already in flight on the stream
  assign desc_ready_o = (desc_cnt < 3);
  assign burst_accept = avmm_req_o.read && !avmm_waitreq_i;

  sync_fifo #(
    .WIDTH ($bits(desc_t)),
    .DEPTH (DESC_FIFO_DEPTH)
  ) u_desc_fifo (
    .Clk_i     (Clk_i),
    .Srst_i    (Srst_i),
    .wr_i      (desc_valid_i && desc_ready_o),
    .wr_data_i (desc_i),
    .rd_i      (desc_pop),
    .rd_data_o (head_desc),
    .count_o   (desc_cnt)
  );

  rd_burst_splitter u_splitter (
    .Clk_i          (Clk_i),
    .Srst_i         (Srst_i),
    .head_desc_i    (head_desc),
    .fifo_empty_i   (desc_cnt == '0),
    .desc_pop_o     (desc_pop),
    .credit_ok_i    (credit_ok),
    .avmm_waitreq_i (avmm_waitreq_i),
    .avmm_req_o     (avmm_req_o),
    .desc_load_o    (desc_load),
    .desc_loaded_o  (desc_loaded)
  );

  rd_credit_ctrl u_credit (
    .Clk_i          (Clk_i),
    .Srst_i         (Srst_i),
    .burst_accept_i (burst_accept),
    .burst_lines_i  (avmm_req_o.burstcount),
    .release_i      (buff_release_i),
    .release_size_i (buff_release_size_i),
    .credit_ok_o    (credit_ok)
  );

  cpl_data_buffer u_buffer (
    .Clk_i         (Clk_i),
    .Srst_i        (Srst_i),
    .rdata_valid_i (avmm_rdata_valid_i),
    .rdata_i       (avmm_rdata_i),
    .rd_addr_i     (ram_rd_addr_i),
    .rd_data_o     (ram_rd_data_o),
    .line_wr_o     (line_wr)
  );

  desc_done_tracker #(
    .DONE_FIFO_DEPTH (DONE_FIFO_DEPTH)
  ) u_tracker (
    .Clk_i         (Clk_i),
    .Srst_i        (Srst_i),
    .desc_load_i   (desc_load),
    .desc_loaded_i (desc_loaded),
    .line_wr_i     (line_wr),
    .done_pop_i    (done_pop_i),
    .done_count_o  (done_count_o)
  );

endmodule

`default_nettype wire
